//--- src/zbt_video_pkg.sv
package zbt_video_pkg;

   //////////////////////////////
   // memory geometry
   //////////////////////////////

   // one ZBT bank has 2^19 words of 36 bits
   localparam int addr_w = 19;
   localparam int word_w = 36;

   //////////////////////////////
   // default XGA 1024x768 timing
   //////////////////////////////

   // horizontal, in pixel clocks
   localparam int def_h_active     = 1024;
   localparam int def_h_sync_start = 1048;
   localparam int def_h_sync_end   = 1184;
   localparam int def_h_total      = 1344;

   // vertical, in lines
   localparam int def_v_active     = 768;
   localparam int def_v_sync_start = 777;
   localparam int def_v_sync_end   = 783;
   localparam int def_v_total      = 806;

   // how far ahead of the beam the memory is read, in pixels
   localparam int def_lookahead    = 8;

   //////////////////////////////
   // video data types
   //////////////////////////////

   // one grey pixel
   typedef logic [7:0] pixel_t;

   // word address into the ZBT
   typedef logic [addr_w-1:0] vram_addr_t;

   // one memory word, seen either as raw pin data or as four pixels
   // pixel 0 sits in the top byte below the spare nibble
   // and is shown first on screen
   typedef union packed {
      // raw bits as they travel on the ram data bus
      logic [word_w-1:0] raw;
      // display view
      struct packed {
         // not used for video, written as zero
         logic [3:0]   spare;
         pixel_t [0:3] px;
      } pix;
   } vram_word_u;

endpackage

//--- src/xga_timing.sv
`timescale 1ns/1ps

module xga_timing #(
   parameter int h_active     = zbt_video_pkg::def_h_active,
   parameter int h_sync_start = zbt_video_pkg::def_h_sync_start,
   parameter int h_sync_end   = zbt_video_pkg::def_h_sync_end,
   parameter int h_total      = zbt_video_pkg::def_h_total,
   parameter int v_active     = zbt_video_pkg::def_v_active,
   parameter int v_sync_start = zbt_video_pkg::def_v_sync_start,
   parameter int v_sync_end   = zbt_video_pkg::def_v_sync_end,
   parameter int v_total      = zbt_video_pkg::def_v_total
) (
   input  logic        clk,
   input  logic        reset,
   output logic [10:0] hcount,
   output logic [9:0]  vcount,
   output logic        hsync,
   output logic        vsync,
   output logic        blank
);

   // separate blank flags per direction
   logic hblank;
   logic vblank;
   logic next_hblank;
   logic next_vblank;

   // horizontal events, true on the last pixel before the change
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic hreset;

   // vertical events, only at the end of a line
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;
   logic vreset;

   assign hblank_on = (hcount == 11'(h_active - 1));
   assign hsync_on  = (hcount == 11'(h_sync_start - 1));
   assign hsync_off = (hcount == 11'(h_sync_end - 1));
   assign hreset    = (hcount == 11'(h_total - 1));

   assign vblank_on = hreset && (vcount == 10'(v_active - 1));
   assign vsync_on  = hreset && (vcount == 10'(v_sync_start - 1));
   assign vsync_off = hreset && (vcount == 10'(v_sync_end - 1));
   assign vreset    = hreset && (vcount == 10'(v_total - 1));

   // blank state for the next pixel
   // so the registered blank lines up with the counters
   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= hreset ? '0 : hcount + 11'd1;
         // line counter steps once per line
         if (hreset) begin
            vcount <= vreset ? '0 : vcount + 10'd1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         // syncs are active low
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         blank  <= next_hblank | next_vblank;
      end
   end

   // counters never leave the frame
   hcount_in_line : assert property (@(posedge clk) disable iff (reset)
      hcount < 11'(h_total));
   vcount_in_frame : assert property (@(posedge clk) disable iff (reset)
      vcount < 10'(v_total));

endmodule

//--- src/vram_fetch.sv
`timescale 1ns/1ps

module vram_fetch #(
   parameter int h_total   = zbt_video_pkg::def_h_total,
   parameter int v_total   = zbt_video_pkg::def_v_total,
   parameter int lookahead = zbt_video_pkg::def_lookahead
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [10:0]                hcount,
   input  logic [9:0]                 vcount,
   output zbt_video_pkg::vram_addr_t  fetch_addr,
   input  zbt_video_pkg::vram_word_u  read_word,
   output zbt_video_pkg::pixel_t      vr_pixel
);

   //////////////////////////////
   // look-ahead position
   //////////////////////////////

   // beam position lookahead pixels from now
   logic [10:0] hcount_f;
   logic [9:0]  vcount_f;
   // look-ahead runs past the end of the line
   logic        wrap;

   assign wrap = (hcount >= 11'(h_total - lookahead));

   always_comb begin
      if (!wrap) begin
         // same line further right
         hcount_f = hcount + 11'(lookahead);
         vcount_f = vcount;
      end else begin
         // start of the following line
         hcount_f = hcount - 11'(h_total - lookahead);
         vcount_f = (vcount == 10'(v_total - 1)) ? '0 : vcount + 10'd1;
      end
   end

   // one word holds four pixels so the low two bits drop out
   assign fetch_addr = {1'b0, vcount_f, hcount_f[9:2]};

   //////////////////////////////
   // read data capture
   //////////////////////////////

   // word as it came back from the memory
   zbt_video_pkg::vram_word_u fetched_word;
   // word whose pixels are on screen now
   zbt_video_pkg::vram_word_u display_word;

   // address presented at low bits 3 is on the pins at 0
   // and its data shows on the bus at 2
   // requests at low bits 2 may be lost to pattern writes
   always_ff @(posedge clk) begin
      if (hcount[1:0] == 2'd2) begin
         fetched_word <= read_word;
      end
   end

   // hand over at the end of a group
   // so all four pixels of the next group come from one word
   always_ff @(posedge clk) begin
      if (hcount[1:0] == 2'd3) begin
         display_word <= fetched_word;
      end
   end

   // pixel n of the word on the n-th clock of its group
   assign vr_pixel = display_word.pix.px[hcount[1:0]];

   // the display word only moves at a group boundary
   display_word_held : assert property (@(posedge clk) disable iff (reset)
      (hcount[1:0] != 2'd3) |=> $stable(display_word));

endmodule

//--- src/pattern_writer.sv
`timescale 1ns/1ps

module pattern_writer (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       stripe_wide,
   input  logic                       write_taken,
   output zbt_video_pkg::vram_addr_t  write_addr,
   output zbt_video_pkg::vram_word_u  write_word
);

   // grey level shared by all four pixels of the word
   zbt_video_pkg::pixel_t stripe;

   //////////////////////////////
   // address counter
   //////////////////////////////

   // sweeps the whole bank and rolls over at 2^19
   // waits on the current word until the port uses its slot
   always_ff @(posedge clk) begin
      if (reset) begin
         write_addr <= '0;
      end else if (write_taken) begin
         write_addr <= write_addr + 1'b1;
      end
   end

   //////////////////////////////
   // stripe data
   //////////////////////////////

   // narrow stripes change every 8 words
   // wide stripes every 16 words
   // low nibble of each pixel stays dark
   assign stripe = stripe_wide ? {write_addr[7:4], 4'b0000}
                               : {write_addr[6:3], 4'b0000};

   always_comb begin
      write_word.pix.spare = 4'b0000;
      write_word.pix.px    = {4{stripe}};
   end

endmodule

//--- src/zbt_port.sv
`timescale 1ns/1ps

module zbt_port (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  blank,
   input  logic [10:0]                           hcount,
   input  logic                                  pattern_write_en,
   input  zbt_video_pkg::vram_addr_t             fetch_addr,
   input  zbt_video_pkg::vram_addr_t             write_addr,
   input  zbt_video_pkg::vram_word_u             write_word,
   output logic                                  write_taken,
   output zbt_video_pkg::vram_word_u             read_word,
   output logic [zbt_video_pkg::addr_w-1:0]      ram_address,
   output logic                                  ram_we_b,
   output logic                                  ram_cen_b,
   output logic [zbt_video_pkg::word_w-1:0]      ram_data_out,
   output logic                                  ram_data_oe,
   input  logic [zbt_video_pkg::word_w-1:0]      ram_data_in
);

   // this cycle belongs to the pattern writer
   logic                      write_slot;
   // write word next to the address on the pins
   zbt_video_pkg::vram_word_u word_q;
   // write word and enable one cycle later
   zbt_video_pkg::vram_word_u word_s1;
   logic                      oe_s1;

   // slot at low bits 2 during blanking
   // the useful read of each group is requested at low bits 3
   assign write_slot  = blank && (hcount[1:0] == 2'd2) && pattern_write_en;
   assign write_taken = write_slot;

   //////////////////////////////
   // request onto the pins
   //////////////////////////////

   always_ff @(posedge clk) begin
      ram_address <= write_slot ? write_addr : fetch_addr;
      word_q      <= write_word;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ram_we_b    <= 1'b1;
         ram_cen_b   <= 1'b0;
         oe_s1       <= 1'b0;
         ram_data_oe <= 1'b0;
      end else begin
         ram_we_b    <= !write_slot;
         // clock enable stays active so the pipeline never stalls
         ram_cen_b   <= 1'b0;
         // bus turns around two cycles after the write command
         oe_s1       <= !ram_we_b;
         ram_data_oe <= oe_s1;
      end
   end

   //////////////////////////////
   // write data pipeline
   //////////////////////////////

   always_ff @(posedge clk) begin
      word_s1      <= word_q;
      ram_data_out <= word_s1.raw;
   end

   // read data goes straight through, the fetch stage picks its cycle
   assign read_word = ram_data_in;

   // data bus driven exactly in the ZBT write data cycle
   write_data_latency : assert property (@(posedge clk) disable iff (reset)
      ram_data_oe == !$past(ram_we_b, 2));

endmodule

//--- src/zbt_video_top.sv
`timescale 1ns/1ps

module zbt_video_top #(
   parameter int h_active     = zbt_video_pkg::def_h_active,
   parameter int h_sync_start = zbt_video_pkg::def_h_sync_start,
   parameter int h_sync_end   = zbt_video_pkg::def_h_sync_end,
   parameter int h_total      = zbt_video_pkg::def_h_total,
   parameter int v_active     = zbt_video_pkg::def_v_active,
   parameter int v_sync_start = zbt_video_pkg::def_v_sync_start,
   parameter int v_sync_end   = zbt_video_pkg::def_v_sync_end,
   parameter int v_total      = zbt_video_pkg::def_v_total,
   parameter int lookahead    = zbt_video_pkg::def_lookahead
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  pattern_write_en,
   input  logic                                  stripe_wide,
   input  logic                                  test_bars,
   output logic [zbt_video_pkg::addr_w-1:0]      ram_address,
   output logic                                  ram_we_b,
   output logic                                  ram_cen_b,
   output logic [zbt_video_pkg::word_w-1:0]      ram_data_out,
   output logic                                  ram_data_oe,
   input  logic [zbt_video_pkg::word_w-1:0]      ram_data_in,
   output zbt_video_pkg::pixel_t                 vga_pixel,
   output logic                                  vga_blank_b,
   output logic                                  vga_hsync,
   output logic                                  vga_vsync
);

   // raster state
   logic [10:0] hcount;
   logic [9:0]  vcount;
   logic        hsync;
   logic        vsync;
   logic        blank;

   // memory traffic between the blocks
   zbt_video_pkg::vram_addr_t fetch_addr;
   zbt_video_pkg::vram_word_u read_word;
   zbt_video_pkg::vram_addr_t write_addr;
   zbt_video_pkg::vram_word_u write_word;
   logic                      write_taken;
   zbt_video_pkg::pixel_t     vr_pixel;

   //////////////////////////////
   // blocks
   //////////////////////////////

   xga_timing #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total)
   ) timing (
      .clk    (clk),
      .reset  (reset),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   vram_fetch #(
      .h_total   (h_total),
      .v_total   (v_total),
      .lookahead (lookahead)
   ) fetch (
      .clk        (clk),
      .reset      (reset),
      .hcount     (hcount),
      .vcount     (vcount),
      .fetch_addr (fetch_addr),
      .read_word  (read_word),
      .vr_pixel   (vr_pixel)
   );

   pattern_writer writer (
      .clk         (clk),
      .reset       (reset),
      .stripe_wide (stripe_wide),
      .write_taken (write_taken),
      .write_addr  (write_addr),
      .write_word  (write_word)
   );

   zbt_port port (
      .clk              (clk),
      .reset            (reset),
      .blank            (blank),
      .hcount           (hcount),
      .pattern_write_en (pattern_write_en),
      .fetch_addr       (fetch_addr),
      .write_addr       (write_addr),
      .write_word       (write_word),
      .write_taken      (write_taken),
      .read_word        (read_word),
      .ram_address      (ram_address),
      .ram_we_b         (ram_we_b),
      .ram_cen_b        (ram_cen_b),
      .ram_data_out     (ram_data_out),
      .ram_data_oe      (ram_data_oe),
      .ram_data_in      (ram_data_in)
   );

   //////////////////////////////
   // output register
   //////////////////////////////

   // hardwired bars are 64 pixels wide in 8 grey steps
   always_ff @(posedge clk) begin
      vga_pixel <= test_bars ? {hcount[8:6], 5'b00000} : vr_pixel;
   end

   // sync and blank take the same single register as the pixel
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_blank_b <= 1'b0;
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
      end else begin
         vga_blank_b <= !blank;
         vga_hsync   <= hsync;
         vga_vsync   <= vsync;
      end
   end

endmodule

//--- tb/zbt_sram_model.sv
`timescale 1ns/1ps

module zbt_sram_model (
   input  logic        clk,
   input  logic [18:0] ram_address,
   input  logic        ram_we_b,
   input  logic        ram_cen_b,
   input  logic [35:0] ram_data_out,
   input  logic        ram_data_oe,
   output logic [35:0] ram_data_in
);

   // one bank of 2^19 words
   logic [35:0] mem [0:(1<<19)-1];

   // address and command two stages deep
   logic [18:0] addr_s1;
   logic [18:0] addr_s2;
   logic        we_s1 = 1'b1;
   logic        we_s2 = 1'b1;

   integer seed;
   integer i;
   integer r_hi;
   integer r_lo;

   // random contents from the fixed seed
   initial begin
      seed = 32'h149d_6465;
      for (i = 0; i < (1 << 19); i = i + 1) begin
         r_hi = $random(seed);
         r_lo = $random(seed);
         mem[i] = {r_hi[3:0], r_lo};
      end
   end

   // pipelined ZBT behavior
   // read data two clocks after the address, write data two clocks after it too
   always @(posedge clk) begin
      if (!ram_cen_b) begin
         addr_s1     <= ram_address;
         we_s1       <= ram_we_b;
         addr_s2     <= addr_s1;
         we_s2       <= we_s1;
         ram_data_in <= mem[addr_s1];
         // bus only carries data when the controller drives it
         if (!we_s2 && ram_data_oe) begin
            mem[addr_s2] <= ram_data_out;
         end
      end
   end

endmodule

//--- tb/tb_zbt_video.sv
`timescale 1ns/1ps

module tb_zbt_video;

   // small frame so a run covers several frames
   localparam int h_active     = 64;
   localparam int h_sync_start = 72;
   localparam int h_sync_end   = 80;
   localparam int h_total      = 96;
   localparam int v_active     = 16;
   localparam int v_sync_start = 17;
   localparam int v_sync_end   = 19;
   localparam int v_total      = 24;
   localparam int lookahead    = 8;
   localparam int frames       = 8;

   // a write waiting to show up in the display path
   typedef struct packed {
      logic [31:0] due;
      logic [18:0] addr;
      logic [35:0] word;
   } pending_write_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        pattern_write_en;
   logic        stripe_wide;
   logic        test_bars;
   logic [18:0] ram_address;
   logic        ram_we_b;
   logic        ram_cen_b;
   logic [35:0] ram_data_out;
   logic        ram_data_oe;
   logic [35:0] ram_data_in;
   logic [7:0]  vga_pixel;
   logic        vga_blank_b;
   logic        vga_hsync;
   logic        vga_vsync;

   integer seed;
   int     errors;
   int     timeouts;

   // reference copy of the memory contents
   logic [35:0]    mirror [0:(1<<19)-1];
   pending_write_t pending[$];

   zbt_video_top #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total),
      .lookahead    (lookahead)
   ) dut (
      .clk              (clk),
      .reset            (reset),
      .pattern_write_en (pattern_write_en),
      .stripe_wide      (stripe_wide),
      .test_bars        (test_bars),
      .ram_address      (ram_address),
      .ram_we_b         (ram_we_b),
      .ram_cen_b        (ram_cen_b),
      .ram_data_out     (ram_data_out),
      .ram_data_oe      (ram_data_oe),
      .ram_data_in      (ram_data_in),
      .vga_pixel        (vga_pixel),
      .vga_blank_b      (vga_blank_b),
      .vga_hsync        (vga_hsync),
      .vga_vsync        (vga_vsync)
   );

   zbt_sram_model sram (
      .clk          (clk),
      .ram_address  (ram_address),
      .ram_we_b     (ram_we_b),
      .ram_cen_b    (ram_cen_b),
      .ram_data_out (ram_data_out),
      .ram_data_oe  (ram_data_oe),
      .ram_data_in  (ram_data_in)
   );

   // 8 ns period
   initial begin
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   // polls off the edge grid and returns 1 ns after the rising edge
   task automatic next_rise();
      int polls;
      polls = 0;
      #0.5;
      while (clk === 1'b1 && polls < 20) begin
         #1;
         polls++;
      end
      while (clk !== 1'b1 && polls < 20) begin
         #1;
         polls++;
      end
      #0.5;
      if (polls >= 20) begin
         timeouts++;
         $display("Timeout at %0t: the clock stopped rising", $time);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [35:0] expected,
                                  input logic [35:0] actual);
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
   endtask

   // new control bits with write enable mostly on and bars now and then
   task automatic draw_controls();
      pattern_write_en = (($random(seed) & 3) != 0);
      stripe_wide      = $random(seed) & 1;
      test_bars        = (($random(seed) & 3) == 0);
   endtask

   // stripe rule with the same grey in all four pixels and a zero top nibble
   function automatic logic [35:0] stripe_word(input logic [18:0] addr, input logic wide);
      logic [7:0] grey;
      grey = wide ? {addr[7:4], 4'b0000} : {addr[6:3], 4'b0000};
      return {4'b0000, grey, grey, grey, grey};
   endfunction

   // pixel 0 sits just below the spare nibble
   function automatic logic [7:0] word_pixel(input logic [35:0] word, input int lane);
      return word[31 - 8*lane -: 8];
   endfunction

   //////////////////////////////
   // stimulus and checks
   //////////////////////////////

   initial begin
      int             i;
      int             h;
      int             v;
      int             frame;
      int             cyc;
      integer         r_hi;
      integer         r_lo;
      logic           exp_blank_b;
      logic           exp_hsync;
      logic           exp_vsync;
      logic           exp_slot;
      logic [7:0]     exp_px;
      logic [35:0]    word;
      logic           slot_d1;
      logic           slot_d2;
      logic [18:0]    addr_d1;
      logic [18:0]    addr_d2;
      logic           wide_d1;
      logic           wide_d2;
      logic [18:0]    next_addr;
      pending_write_t pw;

      errors           = 0;
      timeouts         = 0;
      reset            = 1'b1;
      pattern_write_en = 1'b0;
      stripe_wide      = 1'b0;
      test_bars        = 1'b0;
      seed             = 32'h149d_6465;

      // same preload sequence as the memory model
      for (i = 0; i < (1 << 19); i++) begin
         r_hi = $random(seed);
         r_lo = $random(seed);
         mirror[i] = {r_hi[3:0], r_lo};
      end
      draw_controls();

      repeat (16) next_rise();
      reset = 1'b0;

      // outputs still hold their reset values here
      if (vga_blank_b !== 1'b0) report_mismatch("vga_blank_b", 1'b0, vga_blank_b);
      if (vga_hsync !== 1'b1) report_mismatch("vga_hsync", 1'b1, vga_hsync);
      if (vga_vsync !== 1'b1) report_mismatch("vga_vsync", 1'b1, vga_vsync);
      if (ram_we_b !== 1'b1) report_mismatch("ram_we_b", 1'b1, ram_we_b);
      if (ram_data_oe !== 1'b0) report_mismatch("ram_data_oe", 1'b0, ram_data_oe);
      if (ram_cen_b !== 1'b0) report_mismatch("ram_cen_b", 1'b0, ram_cen_b);

      h         = 0;
      v         = 0;
      frame     = 0;
      cyc       = 0;
      slot_d1   = 1'b0;
      slot_d2   = 1'b0;
      addr_d1   = '0;
      addr_d2   = '0;
      wide_d1   = 1'b0;
      wide_d2   = 1'b0;
      next_addr = '0;

      // (h, v) is the position the outputs show in this cycle
      while (frame < frames && timeouts == 0) begin
         next_rise();

         // a write reaches the screen 10 cycles after its slot
         while (pending.size() > 0 && pending[0].due <= cyc) begin
            pw = pending.pop_front();
            mirror[pw.addr] = pw.word;
         end

         // raster timing
         exp_blank_b = (h < h_active) && (v < v_active);
         exp_hsync   = !((h >= h_sync_start) && (h < h_sync_end));
         exp_vsync   = !((v >= v_sync_start) && (v < v_sync_end));
         if (vga_blank_b !== exp_blank_b) report_mismatch("vga_blank_b", exp_blank_b, vga_blank_b);
         if (vga_hsync !== exp_hsync) report_mismatch("vga_hsync", exp_hsync, vga_hsync);
         if (vga_vsync !== exp_vsync) report_mismatch("vga_vsync", exp_vsync, vga_vsync);

         // write slot of the previous cycle is on the pins now
         exp_slot = !exp_blank_b && (h % 4 == 2) && pattern_write_en;
         if (ram_we_b !== !exp_slot) report_mismatch("ram_we_b", !exp_slot, ram_we_b);
         if (exp_slot && ram_address !== next_addr) begin
            report_mismatch("ram_address", next_addr, ram_address);
         end

         // write data two cycles behind its address
         if (ram_data_oe !== slot_d2) report_mismatch("ram_data_oe", slot_d2, ram_data_oe);
         if (slot_d2) begin
            word = stripe_word(addr_d2, wide_d2);
            if (ram_data_out !== word) report_mismatch("ram_data_out", word, ram_data_out);
            pw.due  = cyc + 8;
            pw.addr = addr_d2;
            pw.word = word;
            pending.push_back(pw);
         end

         // pixels skip the first two groups after reset since they had no fetch
         if (exp_blank_b && cyc >= 8) begin
            if (test_bars) begin
               exp_px = {h[8:6], 5'b00000};
            end else begin
               exp_px = word_pixel(mirror[{1'b0, v[9:0], h[9:2]}], h % 4);
            end
            if (vga_pixel !== exp_px) report_mismatch("vga_pixel", exp_px, vga_pixel);
         end

         slot_d2 = slot_d1;
         addr_d2 = addr_d1;
         wide_d2 = wide_d1;
         slot_d1 = exp_slot;
         addr_d1 = next_addr;
         wide_d1 = stripe_wide;
         if (exp_slot) begin
            next_addr = next_addr + 19'd1;
         end

         cyc++;
         h++;
         if (h == h_total) begin
            h = 0;
            v++;
            if (v == v_total) begin
               v = 0;
               frame++;
               draw_controls();
            end
         end
      end

      $display("Run over: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- zbt_video.f
src/zbt_video_pkg.sv
src/xga_timing.sv
src/vram_fetch.sv
src/pattern_writer.sv
src/zbt_port.sv
src/zbt_video_top.sv
tb/zbt_sram_model.sv
tb/tb_zbt_video.sv
